// ==== bench/operand_tests.txt ====
# name req stall src_en ps1 ps2 ps3 scalar_sel mode scalar idx1-4 lane_in1-3 wb_valid wb_idx wb_data retire wait
# expected op_data1-3 lane_out1-3 (pN port N, sc scalar, lN lane input, - hold, else hex) buff_full
steer_a     1 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p1 p2 p3 0 0 0 0
steer_b     1 0 7 3 2 1 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p4 p3 p2 0 0 0 0
steer_c     1 0 7 1 3 0 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p2 p4 p1 0 0 0 0
steer_d     1 0 7 2 0 3 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p3 p1 p4 0 0 0 0
steer_dis   1 0 5 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p1 0 p3 0 0 0 0
req_low     0 0 7 0 1 2 0 1 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 - - - 0 0 0 0
scalar_1    1 0 7 0 1 2 1 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 sc p2 p3 0 0 0 0
scalar_3    1 0 7 0 1 2 3 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p1 p2 sc 0 0 0 0
scalar_off  1 0 5 0 1 2 2 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p1 0 p3 0 0 0 0
export      1 0 7 0 1 2 2 1 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p1 sc p3 p1 sc p3 0
import      1 0 7 0 1 2 0 2 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 l1 l2 l3 p1 p2 p3 0
pair        1 0 7 0 1 2 0 3 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 l1 l2 l3 p1 p2 p3 0
wb_old      0 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 1 12 d1 0 0 - - - 0 0 0 0
wb_new      0 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 1 12 d2 0 0 - - - 0 0 0 0
fwd_newest  1 0 7 1 1 0 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 d2 d2 p1 0 0 0 0
fwd_scalar  1 0 7 1 1 1 2 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 d2 sc d2 0 0 0 0
fwd_import  1 0 7 1 1 1 0 2 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 l1 l2 l3 p2 p2 p2 0
fill        0 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 1 20 e0 0 1 - - - 0 0 0 1
full_fwd    1 0 7 0 1 2 0 0 5c 20 12 13 14 a1 a2 a3 0 00 00 0 0 e0 d2 p3 0 0 0 1
drain_one   0 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 1 1 - - - 0 0 0 0
drain_two   0 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 1 0 - - - 0 0 0 0
retired     1 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 0 0 p1 p2 p3 0 0 0 0
drain_three 0 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 1 0 - - - 0 0 0 0
stall_hold  1 1 7 0 1 2 0 0 5c 20 12 13 14 a1 a2 a3 0 00 00 1 0 - - - 0 0 0 0
stall_go    1 0 7 0 1 2 0 0 5c 20 12 13 14 a1 a2 a3 0 00 00 0 0 e0 p2 p3 0 0 0 0
wb_retire   0 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 1 30 f3 1 0 - - - 0 0 0 0
fwd_swap    1 0 7 0 1 2 0 0 5c 30 20 13 14 a1 a2 a3 0 00 00 0 0 f3 p2 p3 0 0 0 0
drain_last  0 0 7 0 1 2 0 0 5c 11 12 13 14 a1 a2 a3 0 00 00 1 0 - - - 0 0 0 0

// ==== build.f ====
common/lane_pkg.sv
common/operand_if.sv
source/operand_select.sv
source/path_select.sv
bypass/bypass_buff.sv
source/operand_network.sv
bench/tb_operand_network.sv

// ==== Makefile ====
TB_TOP = tb_operand_network

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module operand_network

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failures found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_operand_network.sv ====
module tb_operand_network
	import lane_pkg::*;
();

	localparam int BUFF_SIZE	= 4;
	localparam int WAIT_LIMIT	= 20;					// Cycles per wait loop
	localparam int LINE_BYTES	= 128;

	logic				clock;
	logic				rst;
	logic				req;
	logic				stall;
	logic [NUM_OPS-1:0]	src_en;
	port_sel_t			port_sel1, port_sel2, port_sel3;
	scalar_sel_t		scalar_sel;
	path_mode_t			path_mode;
	data_t				scalar_data;
	data_t				rd_data [NUM_RD_PORTS];			// Random register file words
	index_t				rd_idx [NUM_RD_PORTS];
	data_t				lane_in [NUM_OPS];
	logic				wb_valid;
	index_t				wb_idx;
	data_t				wb_data;
	logic				retire;
	data_t				op_data1, op_data2, op_data3;
	data_t				lane_out1, lane_out2, lane_out3;
	logic				buff_full;

	logic [15:0]		lfsr_state;
	int					error_count;
	int					pass_count;
	int					fail_count;

	operand_network #(.LANE_ID(0), .BUFF_SIZE(BUFF_SIZE)) u_dut (
		.clock(clock),				.rst(rst),					.req(req),
		.stall(stall),				.src_en(src_en),
		.port_sel1(port_sel1),		.port_sel2(port_sel2),		.port_sel3(port_sel3),
		.scalar_sel(scalar_sel),	.path_mode(path_mode),		.scalar_data(scalar_data),
		.rd_data1(rd_data[0]),		.rd_data2(rd_data[1]),
		.rd_data3(rd_data[2]),		.rd_data4(rd_data[3]),
		.rd_idx1(rd_idx[0]),		.rd_idx2(rd_idx[1]),
		.rd_idx3(rd_idx[2]),		.rd_idx4(rd_idx[3]),
		.lane_in1(lane_in[0]),		.lane_in2(lane_in[1]),		.lane_in3(lane_in[2]),
		.wb_valid(wb_valid),		.wb_idx(wb_idx),			.wb_data(wb_data),
		.retire(retire),
		.op_data1(op_data1),		.op_data2(op_data2),		.op_data3(op_data3),
		.lane_out1(lane_out1),		.lane_out2(lane_out2),		.lane_out3(lane_out3),
		.buff_full(buff_full)
	);

	//////////////////////////////////////////////////
	// Helpers

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_word(output data_t word);
		for (int b = 0; b < DATA_W; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			word = {word[DATA_W-2:0], lfsr_state[0]};
		end
	endtask

	// Text from $fgets sits right justified
	function automatic logic [7:0] first_char(input logic [8*LINE_BYTES-1:0] text);
		logic [7:0]	ch;
		ch = 8'h00;
		for (int i = 0; i < LINE_BYTES; i++) begin
			if (text[8*i +: 8] != 8'h00) begin
				ch = text[8*i +: 8];
			end
		end
		return ch;
	endfunction

	// Source token to word, anything unknown is a hex literal
	function automatic data_t resolve_expected(input string tok, input data_t prev);
		data_t	val;
		val = '0;
		case (tok)
			"p1":		val = rd_data[0];
			"p2":		val = rd_data[1];
			"p3":		val = rd_data[2];
			"p4":		val = rd_data[3];
			"sc":		val = scalar_data;
			"l1":		val = lane_in[0];
			"l2":		val = lane_in[1];
			"l3":		val = lane_in[2];
			"-":		val = prev;						// Output register holds
			default:	void'($sscanf(tok, "%h", val));
		endcase
		return val;
	endfunction

	task automatic check_value(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	//////////////////////////////////////////////////
	// Clock

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Stimulus and checking

	initial begin
		int						fd;
		int						fields;
		int						errors_before;
		int						cycles;
		logic [8*LINE_BYTES-1:0]	line_buf;
		logic [8*16-1:0]		test_name;
		logic [1:0]				mode_v;
		logic [31:0]			wait_flag;
		logic [31:0]			exp_full;
		string					tok [6];
		data_t					exp_op [NUM_OPS];
		data_t					exp_lane [NUM_OPS];
		data_t					prev_op [NUM_OPS];

		rst = 1'b1;
		{req, stall, src_en, wb_valid, retire} = '0;
		{port_sel1, port_sel2, port_sel3, scalar_sel} = '0;
		path_mode = PATH_LOCAL;
		scalar_data = '0;
		rd_data = '{default: '0};
		rd_idx = '{default: '0};
		lane_in = '{default: '0};
		wb_idx = '0;
		wb_data = '0;
		prev_op = '{default: '0};						// Outputs clear after reset
		lfsr_state = 16'd68;
		{error_count, pass_count, fail_count} = '0;

		repeat (16) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;

		cycles = 0;
		while (buff_full !== 1'b0 && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (buff_full !== 1'b0) begin
			$display("Timeout: buff_full stayed high after reset");
			error_count++;
		end

		fd = $fopen("bench/operand_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/operand_tests.txt");
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				if ($fgets(line_buf, fd) == 0) break;
				if (first_char(line_buf) == "#" || first_char(line_buf) == "\n"
						|| first_char(line_buf) == 8'h00) continue;
				errors_before = error_count;

				// Inputs change here, on the falling edge
				fields = $sscanf(line_buf,
					"%s%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%s%s%s%s%s%s%h",
					test_name, req, stall, src_en, port_sel1, port_sel2, port_sel3,
					scalar_sel, mode_v, scalar_data, rd_idx[0], rd_idx[1], rd_idx[2],
					rd_idx[3], lane_in[0], lane_in[1], lane_in[2], wb_valid, wb_idx,
					wb_data, retire, wait_flag, tok[0], tok[1], tok[2], tok[3], tok[4],
					tok[5], exp_full);
				if (fields != 29) begin
					$display("Malformed line in test file, %0d fields read", fields);
					error_count++;
					fail_count++;
					continue;
				end
				path_mode = path_mode_t'(mode_v);
				for (int k = 0; k < NUM_RD_PORTS; k++) begin
					random_word(rd_data[k]);
				end
				for (int k = 0; k < NUM_OPS; k++) begin
					exp_op[k] = resolve_expected(tok[k], prev_op[k]);
					exp_lane[k] = resolve_expected(tok[NUM_OPS+k], '0);
				end

				// Held inputs repeat until buff_full reaches the expected level
				cycles = 0;
				do begin
					@(posedge clock);
					@(negedge clock);
					cycles++;
				end while (wait_flag != 0 && buff_full !== exp_full[0] && cycles < WAIT_LIMIT);
				if (wait_flag != 0 && buff_full !== exp_full[0]) begin
					$display("Timeout in %0s: buff_full did not reach %0d in %0d cycles",
						test_name, exp_full[0], WAIT_LIMIT);
					error_count++;
				end

				check_value("op_data1", exp_op[0], op_data1);
				check_value("op_data2", exp_op[1], op_data2);
				check_value("op_data3", exp_op[2], op_data3);
				check_value("lane_out1", exp_lane[0], lane_out1);
				check_value("lane_out2", exp_lane[1], lane_out2);
				check_value("lane_out3", exp_lane[2], lane_out3);
				check_value("buff_full", exp_full, data_t'(buff_full));
				prev_op = exp_op;

				if (error_count == errors_before) begin
					$display("Test %0s passed", test_name);
					pass_count++;
				end else begin
					$display("Test %0s failed", test_name);
					fail_count++;
				end
			end
			$fclose(fd);
		end

		$display("Tests run: %0d, passed: %0d, failed: %0d",
			pass_count + fail_count, pass_count, fail_count);
		if (error_count == 0 && fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== source/operand_network.sv ====
module operand_network
	import lane_pkg::*;
#(
	parameter int LANE_ID		= 0,
	parameter int BUFF_SIZE		= 4
)(
	input	logic				clock,
	input	logic				rst,
	input	logic				req,
	input	logic				stall,
	input	logic [NUM_OPS-1:0]	src_en,					// Operand enables
	input	port_sel_t			port_sel1,
	input	port_sel_t			port_sel2,
	input	port_sel_t			port_sel3,
	input	scalar_sel_t		scalar_sel,
	input	path_mode_t			path_mode,
	input	data_t				scalar_data,			// From scalar unit
	input	data_t				rd_data1,				// From register file
	input	data_t				rd_data2,
	input	data_t				rd_data3,
	input	data_t				rd_data4,
	input	index_t				rd_idx1,
	input	index_t				rd_idx2,
	input	index_t				rd_idx3,
	input	index_t				rd_idx4,
	input	data_t				lane_in1,				// From neighbouring lane
	input	data_t				lane_in2,
	input	data_t				lane_in3,
	input	logic				wb_valid,				// Writeback from ALU
	input	index_t				wb_idx,
	input	data_t				wb_data,
	input	logic				retire,
	output	data_t				op_data1,				// To execution unit
	output	data_t				op_data2,
	output	data_t				op_data3,
	output	data_t				lane_out1,				// To neighbouring lane
	output	data_t				lane_out2,
	output	data_t				lane_out3,
	output	logic				buff_full
);

	operand_if	sel_bus ();								// Steered operands
	operand_if	path_bus ();							// After lane path

	operand_select u_operand_select (
		.req(req),					.src_en(src_en),
		.port_sel1(port_sel1),		.port_sel2(port_sel2),		.port_sel3(port_sel3),
		.scalar_sel(scalar_sel),	.scalar_data(scalar_data),
		.rd_data1(rd_data1),		.rd_data2(rd_data2),
		.rd_data3(rd_data3),		.rd_data4(rd_data4),
		.rd_idx1(rd_idx1),			.rd_idx2(rd_idx2),
		.rd_idx3(rd_idx3),			.rd_idx4(rd_idx4),
		.bus(sel_bus.src)
	);

	path_select #(.LANE_ID(LANE_ID)) u_path_select (
		.path_mode(path_mode),
		.lane_in1(lane_in1),		.lane_in2(lane_in2),		.lane_in3(lane_in3),
		.in_bus(sel_bus.dst),		.out_bus(path_bus.src),
		.lane_out1(lane_out1),		.lane_out2(lane_out2),		.lane_out3(lane_out3)
	);

	bypass_buff #(.BUFF_SIZE(BUFF_SIZE)) u_bypass_buff (
		.clock(clock),				.rst(rst),					.stall(stall),
		.wb_valid(wb_valid),		.wb_idx(wb_idx),			.wb_data(wb_data),
		.retire(retire),			.bus(path_bus.dst),
		.op_data1(op_data1),		.op_data2(op_data2),		.op_data3(op_data3),
		.buff_full(buff_full)
	);

endmodule

// ==== bypass/bypass_buff.sv ====
module bypass_buff
	import lane_pkg::*;
#(
	parameter int BUFF_SIZE		= 4
)(
	input	logic				clock,
	input	logic				rst,
	input	logic				stall,					// Hold outputs, no retire
	input	logic				wb_valid,
	input	index_t				wb_idx,					// Writeback register index
	input	data_t				wb_data,				// Writeback word from ALU
	input	logic				retire,					// Oldest entry absorbed by register file
	operand_if.dst				bus,
	output	data_t				op_data1,				// To execution unit
	output	data_t				op_data2,
	output	data_t				op_data3,
	output	logic				buff_full
);

	localparam int PTR_W		= $clog2(BUFF_SIZE);
	localparam int CNT_W		= $clog2(BUFF_SIZE + 1);

	index_t				ent_idx [BUFF_SIZE];
	data_t				ent_data [BUFF_SIZE];

	logic [PTR_W-1:0]	wr_ptr;
	logic [PTR_W-1:0]	rd_ptr;							// Oldest entry
	logic [CNT_W-1:0]	count;

	logic				wr_en;
	logic				rd_en;

	data_t				fwd_data1;
	data_t				fwd_data2;
	data_t				fwd_data3;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(BUFF_SIZE - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Walk oldest to newest so the newest match wins
	function automatic data_t forward(input index_t idx, input data_t reg_data);
		data_t	res;
		int		pos;
		res = reg_data;
		if (idx != '0) begin
			for (int i = 0; i < BUFF_SIZE; i++) begin
				pos = int'(rd_ptr) + i;
				if (pos >= BUFF_SIZE) begin
					pos = pos - BUFF_SIZE;
				end
				if ((i < int'(count)) && (ent_idx[pos] == idx)) begin
					res = ent_data[pos];
				end
			end
		end
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Writeback FIFO

	assign buff_full	= (count == CNT_W'(BUFF_SIZE));
	assign wr_en		= wb_valid && (wb_idx != '0) && !buff_full;	// Entry dropped when full
	assign rd_en		= retire && !stall && (count != '0);

	always_ff @(posedge clock) begin
		if (wr_en) begin
			ent_idx[wr_ptr]		<= wb_idx;
			ent_data[wr_ptr]	<= wb_data;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (wr_en) begin
				wr_ptr	<= ptr_next(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr	<= ptr_next(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;			// Both or neither
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Forwarding and output stage

	always_comb begin
		fwd_data1	= forward(bus.idx1, bus.data1);
		fwd_data2	= forward(bus.idx2, bus.data2);
		fwd_data3	= forward(bus.idx3, bus.data3);
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			op_data1	<= '0;
			op_data2	<= '0;
			op_data3	<= '0;
		end else if (bus.req && !stall) begin
			op_data1	<= fwd_data1;
			op_data2	<= fwd_data2;
			op_data3	<= fwd_data3;
		end
	end

	a_no_write_full: assert property (@(posedge clock) disable iff (rst)
		(wb_valid && (wb_idx != '0)) |-> !buff_full)
		else $error("writeback while bypass buffer full");

	a_no_retire_empty: assert property (@(posedge clock) disable iff (rst)
		(retire && !stall) |-> (count != '0))
		else $error("retire while bypass buffer empty");

	a_count_bound: assert property (@(posedge clock) disable iff (rst)
		count <= CNT_W'(BUFF_SIZE))
		else $error("bypass buffer count overflow");

endmodule

// ==== source/path_select.sv ====
module path_select
	import lane_pkg::*;
#(
	parameter int LANE_ID		= 0
)(
	input	path_mode_t			path_mode,
	input	data_t				lane_in1,				// From neighbouring lane
	input	data_t				lane_in2,
	input	data_t				lane_in3,
	operand_if.dst				in_bus,					// Steered operands
	operand_if.src				out_bus,				// Operands after lane path
	output	data_t				lane_out1,				// To neighbouring lane
	output	data_t				lane_out2,
	output	data_t				lane_out3
);

	localparam bit LANE_EVEN	= lane_is_even(LANE_ID);

	logic		mode_import;
	logic		mode_export;
	logic		take_lane;
	logic		give_lane;

	//////////////////////////////////////////////////
	// Mode decode

	always_comb begin
		case (path_mode)
			PATH_LOCAL: begin
				mode_import	= 1'b0;
				mode_export	= 1'b0;
			end
			PATH_EXPORT: begin
				mode_import	= 1'b0;
				mode_export	= 1'b1;
			end
			PATH_IMPORT: begin
				mode_import	= 1'b1;						// Importer still hands its own operands out
				mode_export	= 1'b1;
			end
			default: begin								// PATH_PAIR
				mode_import	= LANE_EVEN;
				mode_export	= 1'b1;
			end
		endcase
	end

	assign take_lane	= in_bus.req & mode_import;
	assign give_lane	= in_bus.req & mode_export;

	//////////////////////////////////////////////////
	// Operand and lane outputs

	assign out_bus.req		= in_bus.req;

	assign out_bus.data1	= take_lane ? lane_in1 : in_bus.data1;
	assign out_bus.data2	= take_lane ? lane_in2 : in_bus.data2;
	assign out_bus.data3	= take_lane ? lane_in3 : in_bus.data3;

	// Imported words belong to another lane's register file
	assign out_bus.idx1		= take_lane ? '0 : in_bus.idx1;
	assign out_bus.idx2		= take_lane ? '0 : in_bus.idx2;
	assign out_bus.idx3		= take_lane ? '0 : in_bus.idx3;

	assign lane_out1		= give_lane ? in_bus.data1 : '0;
	assign lane_out2		= give_lane ? in_bus.data2 : '0;
	assign lane_out3		= give_lane ? in_bus.data3 : '0;

endmodule

// ==== source/operand_select.sv ====
module operand_select
	import lane_pkg::*;
(
	input	logic				req,
	input	logic [NUM_OPS-1:0]	src_en,					// One enable per operand
	input	port_sel_t			port_sel1,				// Read port for operand 1
	input	port_sel_t			port_sel2,				// Read port for operand 2
	input	port_sel_t			port_sel3,				// Read port for operand 3
	input	scalar_sel_t		scalar_sel,
	input	data_t				scalar_data,			// From scalar unit
	input	data_t				rd_data1,				// Register file read data
	input	data_t				rd_data2,
	input	data_t				rd_data3,
	input	data_t				rd_data4,
	input	index_t				rd_idx1,				// Register file read index
	input	index_t				rd_idx2,
	input	index_t				rd_idx3,
	input	index_t				rd_idx4,
	operand_if.src				bus
);

	data_t		port_data [NUM_RD_PORTS];
	index_t		port_idx [NUM_RD_PORTS];
	port_sel_t	port_sel [NUM_OPS];

	data_t		slot_data [NUM_OPS];
	index_t		slot_idx [NUM_OPS];

	//////////////////////////////////////////////////
	// Read ports and selects as arrays

	assign port_data	= '{rd_data1, rd_data2, rd_data3, rd_data4};
	assign port_idx		= '{rd_idx1, rd_idx2, rd_idx3, rd_idx4};
	assign port_sel		= '{port_sel1, port_sel2, port_sel3};

	//////////////////////////////////////////////////
	// Operand slot steering

	always_comb begin
		for (int k = 0; k < NUM_OPS; k++) begin
			if (req && src_en[k]) begin
				slot_data[k]	= port_data[port_sel[k]];
				slot_idx[k]		= port_idx[port_sel[k]];

				// The scalar has no register behind it, so it carries index
				// zero and is never replaced further down by the bypass buffer
				if (scalar_sel == scalar_sel_t'(k + 1)) begin
					slot_data[k]	= scalar_data;
					slot_idx[k]		= '0;
				end
			end else begin
				slot_data[k]	= '0;						// Disabled or idle slot
				slot_idx[k]		= '0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Bus drive

	assign bus.req		= req;

	assign bus.data1	= slot_data[0];
	assign bus.data2	= slot_data[1];
	assign bus.data3	= slot_data[2];

	assign bus.idx1		= slot_idx[0];
	assign bus.idx2		= slot_idx[1];
	assign bus.idx3		= slot_idx[2];

endmodule

// ==== common/operand_if.sv ====
interface operand_if
	import lane_pkg::*;
();

	logic		req;									// Request valid for this cycle

	data_t		data1;									// Operand data
	data_t		data2;
	data_t		data3;

	index_t		idx1;									// Register index, zero for none
	index_t		idx2;
	index_t		idx3;

	modport src (
		output	req,
		output	data1, data2, data3,
		output	idx1, idx2, idx3
	);

	modport dst (
		input	req,
		input	data1, data2, data3,
		input	idx1, idx2, idx3
	);

endinterface

// ==== common/lane_pkg.sv ====
package lane_pkg;

	//////////////////////////////////////////////////
	// Widths

	localparam int DATA_W		= 32;					// One lane data word
	localparam int INDEX_W		= 8;					// Register file index

	localparam int NUM_RD_PORTS	= 4;					// Register file read ports
	localparam int NUM_OPS		= 3;					// Execution operands per request

	//////////////////////////////////////////////////
	// Payload types

	typedef logic [DATA_W-1:0]	data_t;					// Operand or writeback word

	// Index zero stands for "no register" and never matches the bypass buffer
	typedef logic [INDEX_W-1:0]	index_t;

	typedef logic [1:0]			port_sel_t;				// Read port number, 0 to 3

	// Zero leaves all operands alone, k puts the scalar into operand k
	typedef logic [1:0]			scalar_sel_t;

	//////////////////////////////////////////////////
	// Lane path modes

	typedef enum logic [1:0] {
		PATH_LOCAL	= 2'd0,								// Operands pass, lane outputs zero
		PATH_EXPORT	= 2'd1,								// Operands pass, lane outputs local operands
		PATH_IMPORT	= 2'd2,								// Operands from lane inputs
		PATH_PAIR	= 2'd3								// Even lanes import, odd lanes export
	} path_mode_t;

	// Even lanes act as importers in PATH_PAIR
	function automatic bit lane_is_even(input int lane_id);
		return (lane_id % 2) == 0;
	endfunction

endpackage
